//--- common/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // Associativity is fixed by the design.
  localparam int NUM_WAYS = 4;

  // Byte address from the client.
  typedef logic [31:0] addr_t;

  // One cache line holds exactly one of these.
  typedef logic [31:0] word_t;

  // Byte enable, also used for the readable mask of a line.
  typedef logic [3:0] be_t;

  typedef logic [1:0] way_t;

  // Controller states.
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MEM_WRITE,
    MEM_READ,
    FILL
  } cache_state_e;

endpackage

`default_nettype wire

//--- design/cache_req_in.sv
`default_nettype none

module cache_req_in
  import cache_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rest,
  input  wire logic  req_valid,
  output logic       req_ready,
  input  wire logic  req_write,
  input  wire addr_t req_addr,
  input  wire be_t   req_be,
  input  wire word_t req_wdata,
  output logic       buf_valid,
  input  wire logic  buf_ready,
  output logic       buf_write,
  output addr_t      buf_addr,
  output be_t        buf_be,
  output word_t      buf_wdata
);

  logic full;

  assign req_ready = !full;
  assign buf_valid = full;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      full <= 1'b0;
    end else if (req_valid && req_ready) begin
      full <= 1'b1;
    end else if (full && buf_ready) begin
      full <= 1'b0;
    end
  end

  // Request fields, captured on acceptance.
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      buf_write <= req_write;
      buf_addr  <= req_addr;
      buf_be    <= req_be;
      buf_wdata <= req_wdata;
    end
  end

  // A request must touch at least one byte.
  assert property (@(posedge clk) disable iff (!rest)
    req_valid && req_ready |-> req_be != '0)
    else $error("request accepted with empty byte enable");

endmodule

`default_nettype wire

//--- cache_core/cache_tag_store.sv
`default_nettype none

module cache_tag_store
  import cache_pkg::*;
#(
  parameter int SET_BITS = 4
) (
  input  wire logic  clk,
  input  wire logic  rest,
  input  wire addr_t lookup_addr,
  output logic       hit,
  output way_t       hit_way,
  output way_t       alloc_way,
  input  wire logic  alloc_en
);

  localparam int TAG_BITS = 30 - SET_BITS;
  localparam int NUM_SETS = 1 << SET_BITS;

  logic [TAG_BITS-1:0] tag_mem [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_mem [NUM_SETS];
  way_t                victim;
  logic [SET_BITS-1:0] set_idx;
  logic [TAG_BITS-1:0] tag;
  logic [NUM_WAYS-1:0] match;
  logic [NUM_WAYS-1:0] set_valid;
  way_t                free_way;

  assign set_idx   = lookup_addr[SET_BITS+1:2];
  assign tag       = lookup_addr[31:SET_BITS+2];
  assign set_valid = valid_mem[set_idx];

  always_comb begin
    match   = '0;
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = set_valid[w] && (tag_mem[set_idx][w] == tag);
      if (match[w]) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Scan downwards so the lowest invalid way wins.
  always_comb begin
    free_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!set_valid[w]) begin
        free_way = way_t'(w);
      end
    end
  end

  // Full set falls back to the round-robin victim.
  assign alloc_way = (&set_valid) ? victim : free_way;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[s] <= '0;
      end
      victim <= '0;
    end else if (alloc_en) begin
      valid_mem[set_idx][alloc_way] <= 1'b1;
      if (&set_valid) begin
        victim <= victim + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_en) begin
      tag_mem[set_idx][alloc_way] <= tag;
    end
  end

  // A tag lives in at most one way of its set.
  assert property (@(posedge clk) disable iff (!rest) $onehot0(match))
    else $error("tag matches more than one way");

endmodule

`default_nettype wire

//--- cache_core/cache_data_store.sv
`default_nettype none

module cache_data_store
  import cache_pkg::*;
#(
  parameter int SET_BITS = 4
) (
  input  wire logic  clk,
  input  wire logic  rest,
  input  wire addr_t addr,
  input  wire way_t  way,
  output word_t      rd_word,
  output be_t        rd_readable,
  input  wire logic  wr_en,
  input  wire be_t   wr_be,
  input  wire word_t wr_data,
  input  wire logic  fill_en,
  input  wire word_t fill_data,
  input  wire logic  invalidate_en
);

  localparam int NUM_SETS  = 1 << SET_BITS;
  localparam int NUM_BYTES = $bits(be_t);

  word_t               data_mem [NUM_SETS][NUM_WAYS];
  be_t                 readable_mem [NUM_SETS][NUM_WAYS];
  logic [SET_BITS-1:0] set_idx;

  assign set_idx     = addr[SET_BITS+1:2];
  assign rd_word     = data_mem[set_idx][way];
  assign rd_readable = readable_mem[set_idx][way];

  // Refill only touches bytes the cache does not already own.
  always_ff @(posedge clk) begin
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (wr_en && wr_be[b]) begin
        data_mem[set_idx][way][8*b +: 8] <= wr_data[8*b +: 8];
      end else if (fill_en && !rd_readable[b]) begin
        data_mem[set_idx][way][8*b +: 8] <= fill_data[8*b +: 8];
      end
    end
  end

  // Fresh allocation starts with nothing readable.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          readable_mem[s][w] <= '0;
        end
      end
    end else if (fill_en) begin
      readable_mem[set_idx][way] <= '1;
    end else if (wr_en || invalidate_en) begin
      readable_mem[set_idx][way] <= (invalidate_en ? '0 : rd_readable) |
                                    (wr_en ? wr_be : '0);
    end
  end

endmodule

`default_nettype wire

//--- cache_core/cache_ctrl.sv
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
#(
  parameter int SET_BITS = 4
) (
  input  wire logic  clk,
  input  wire logic  rest,
  input  wire logic  buf_valid,
  output logic       buf_ready,
  input  wire logic  buf_write,
  input  wire addr_t buf_addr,
  input  wire be_t   buf_be,
  input  wire word_t buf_wdata,
  output addr_t      lookup_addr,
  input  wire logic  hit,
  input  wire way_t  hit_way,
  input  wire way_t  alloc_way,
  output logic       alloc_en,
  output way_t       way,
  input  wire word_t rd_word,
  input  wire be_t   rd_readable,
  output logic       wr_en,
  output be_t        wr_be,
  output word_t      wr_data,
  output logic       fill_en,
  output word_t      fill_data,
  output logic       invalidate_en,
  output logic       rsp_load,
  output word_t      rsp_load_data,
  input  wire logic  rsp_empty,
  output logic       mem_req_valid,
  input  wire logic  mem_req_ready,
  output logic       mem_req_write,
  output addr_t      mem_req_addr,
  output be_t        mem_req_be,
  output word_t      mem_req_wdata,
  input  wire logic  mem_rsp_valid,
  input  wire word_t mem_rsp_data
);

  cache_state_e state;
  cache_state_e state_next;
  logic         req_write;
  addr_t        req_addr;
  be_t          req_be;
  word_t        req_wdata;
  way_t         way_q;
  logic         take;
  logic         readable_ok;
  word_t        fill_merged;

  // Set index plus tag must fit in a word address.
  if (SET_BITS < 1 || SET_BITS > 16) begin : g_bad_set_bits
    $error("SET_BITS out of range");
  end

  // Only start when a read result has somewhere to go.
  assign buf_ready   = (state == IDLE) && rsp_empty;
  assign take        = buf_valid && buf_ready;
  assign lookup_addr = req_addr;
  assign readable_ok = hit && ((rd_readable & req_be) == req_be);

  assign alloc_en      = (state == LOOKUP) && !hit;
  assign invalidate_en = alloc_en;
  assign way           = (state == LOOKUP) ? (hit ? hit_way : alloc_way) : way_q;
  assign wr_en         = (state == LOOKUP) && req_write;
  assign wr_be         = req_be;
  assign wr_data       = req_wdata;
  assign fill_en       = (state == FILL) && mem_rsp_valid;
  assign fill_data     = mem_rsp_data;

  // Cached readable bytes win over memory.
  always_comb begin
    for (int b = 0; b < $bits(be_t); b++) begin
      fill_merged[8*b +: 8] = rd_readable[b] ? rd_word[8*b +: 8] : mem_rsp_data[8*b +: 8];
    end
  end

  assign rsp_load      = ((state == LOOKUP) && !req_write && readable_ok) || fill_en;
  assign rsp_load_data = (state == FILL) ? fill_merged : rd_word;

  assign mem_req_valid = (state == MEM_WRITE) || (state == MEM_READ);
  assign mem_req_write = (state == MEM_WRITE);
  assign mem_req_addr  = {req_addr[31:2], 2'b00};
  assign mem_req_be    = (state == MEM_WRITE) ? req_be : '1;
  assign mem_req_wdata = req_wdata;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (take) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        if (req_write) begin
          state_next = MEM_WRITE;
        end else if (readable_ok) begin
          state_next = IDLE;
        end else begin
          state_next = MEM_READ;
        end
      end
      MEM_WRITE: begin
        if (mem_req_ready) begin
          state_next = IDLE;
        end
      end
      MEM_READ: begin
        if (mem_req_ready) begin
          state_next = FILL;
        end
      end
      FILL: begin
        if (mem_rsp_valid) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req_write <= buf_write;
      req_addr  <= buf_addr;
      req_be    <= buf_be;
      req_wdata <= buf_wdata;
    end
    if (state == LOOKUP) begin
      way_q <= way;
    end
  end

  // Stalled memory command stays put.
  assert property (@(posedge clk) disable iff (!rest)
    mem_req_valid && !mem_req_ready |=>
      mem_req_valid && $stable(mem_req_write) && $stable(mem_req_addr))
    else $error("memory request dropped or changed before acceptance");

  // The refilled line is present in the tag store at the chosen way.
  assert property (@(posedge clk) disable iff (!rest)
    state == FILL |-> hit && hit_way == way_q)
    else $error("refill way not present in tag store");

endmodule

`default_nettype wire

//--- design/cache_rsp_out.sv
`default_nettype none

module cache_rsp_out
  import cache_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rest,
  input  wire logic  rsp_load,
  input  wire word_t rsp_load_data,
  output logic       rsp_empty,
  output logic       rsp_valid,
  input  wire logic  rsp_ready,
  output word_t      rsp_data
);

  assign rsp_empty = !rsp_valid;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      rsp_valid <= 1'b0;
    end else if (rsp_load && rsp_empty) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_load && rsp_empty) begin
      rsp_data <= rsp_load_data;
    end
  end

  // Held response must not change under back-pressure.
  assert property (@(posedge clk) disable iff (!rest)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else $error("response changed while waiting for the client");

endmodule

`default_nettype wire

//--- design/cache_top.sv
`default_nettype none

module cache_top
  import cache_pkg::*;
#(
  parameter int SET_BITS = 4
) (
  input  wire logic  clk,
  input  wire logic  rest,
  input  wire logic  req_valid,
  output logic       req_ready,
  input  wire logic  req_write,
  input  wire addr_t req_addr,
  input  wire be_t   req_be,
  input  wire word_t req_wdata,
  output logic       rsp_valid,
  input  wire logic  rsp_ready,
  output word_t      rsp_data,
  output logic       mem_req_valid,
  input  wire logic  mem_req_ready,
  output logic       mem_req_write,
  output addr_t      mem_req_addr,
  output be_t        mem_req_be,
  output word_t      mem_req_wdata,
  input  wire logic  mem_rsp_valid,
  input  wire word_t mem_rsp_data
);

  logic  buf_valid;
  logic  buf_ready;
  logic  buf_write;
  addr_t buf_addr;
  be_t   buf_be;
  word_t buf_wdata;
  addr_t lookup_addr;
  logic  hit;
  way_t  hit_way;
  way_t  alloc_way;
  logic  alloc_en;
  way_t  way;
  word_t rd_word;
  be_t   rd_readable;
  logic  wr_en;
  be_t   wr_be;
  word_t wr_data;
  logic  fill_en;
  word_t fill_data;
  logic  invalidate_en;
  logic  rsp_load;
  word_t rsp_load_data;
  logic  rsp_empty;

  cache_req_in u_req_in (
    .clk       (clk),
    .rest      (rest),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_be    (req_be),
    .req_wdata (req_wdata),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready),
    .buf_write (buf_write),
    .buf_addr  (buf_addr),
    .buf_be    (buf_be),
    .buf_wdata (buf_wdata)
  );

  cache_ctrl #(
    .SET_BITS (SET_BITS)
  ) u_ctrl (
    .clk           (clk),
    .rest          (rest),
    .buf_valid     (buf_valid),
    .buf_ready     (buf_ready),
    .buf_write     (buf_write),
    .buf_addr      (buf_addr),
    .buf_be        (buf_be),
    .buf_wdata     (buf_wdata),
    .lookup_addr   (lookup_addr),
    .hit           (hit),
    .hit_way       (hit_way),
    .alloc_way     (alloc_way),
    .alloc_en      (alloc_en),
    .way           (way),
    .rd_word       (rd_word),
    .rd_readable   (rd_readable),
    .wr_en         (wr_en),
    .wr_be         (wr_be),
    .wr_data       (wr_data),
    .fill_en       (fill_en),
    .fill_data     (fill_data),
    .invalidate_en (invalidate_en),
    .rsp_load      (rsp_load),
    .rsp_load_data (rsp_load_data),
    .rsp_empty     (rsp_empty),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_be    (mem_req_be),
    .mem_req_wdata (mem_req_wdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  cache_tag_store #(
    .SET_BITS (SET_BITS)
  ) u_tag_store (
    .clk         (clk),
    .rest        (rest),
    .lookup_addr (lookup_addr),
    .hit         (hit),
    .hit_way     (hit_way),
    .alloc_way   (alloc_way),
    .alloc_en    (alloc_en)
  );

  // Data store sees the same request address as the tag store.
  cache_data_store #(
    .SET_BITS (SET_BITS)
  ) u_data_store (
    .clk           (clk),
    .rest          (rest),
    .addr          (lookup_addr),
    .way           (way),
    .rd_word       (rd_word),
    .rd_readable   (rd_readable),
    .wr_en         (wr_en),
    .wr_be         (wr_be),
    .wr_data       (wr_data),
    .fill_en       (fill_en),
    .fill_data     (fill_data),
    .invalidate_en (invalidate_en)
  );

  cache_rsp_out u_rsp_out (
    .clk           (clk),
    .rest          (rest),
    .rsp_load      (rsp_load),
    .rsp_load_data (rsp_load_data),
    .rsp_empty     (rsp_empty),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_data      (rsp_data)
  );

endmodule

`default_nettype wire

//--- tests/cache_mem_model.sv
`default_nettype none

module cache_mem_model
  import cache_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rest,
  input  wire logic  mem_req_valid,
  output logic       mem_req_ready,
  input  wire logic  mem_req_write,
  input  wire addr_t mem_req_addr,
  input  wire be_t   mem_req_be,
  input  wire word_t mem_req_wdata,
  output logic       mem_rsp_valid,
  output word_t      mem_rsp_data
);

  timeunit 1ns;
  timeprecision 1ps;

  integer seed = 32'he407_6fc9;
  word_t  store [addr_t];
  logic   pending;
  int     delay;
  word_t  read_word;

  // Words never written read back as the inverted address.
  function automatic word_t peek(addr_t addr);
    if (store.exists(addr)) begin
      return store[addr];
    end
    return ~addr;
  endfunction

  initial begin
    word_t merged;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    pending       = 1'b0;
    delay         = 0;
    read_word     = '0;
    forever begin
      @(posedge clk);
      if (!rest) begin
        mem_req_ready <= 1'b0;
        mem_rsp_valid <= 1'b0;
        pending = 1'b0;
      end else begin
        mem_rsp_valid <= 1'b0;
        // Pending read answers after its random latency.
        if (pending) begin
          if (delay <= 1) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp_data  <= read_word;
            pending = 1'b0;
          end else begin
            delay = delay - 1;
          end
        end
        if (mem_req_valid && mem_req_ready) begin
          if (mem_req_write) begin
            merged = peek(mem_req_addr);
            for (int b = 0; b < 4; b++) begin
              if (mem_req_be[b]) begin
                merged[8*b +: 8] = mem_req_wdata[8*b +: 8];
              end
            end
            store[mem_req_addr] = merged;
          end else begin
            read_word = peek(mem_req_addr);
            delay     = 1 + ({$random(seed)} % 4);
            pending   = 1'b1;
          end
        end
        // Ready is high about two cycles in three.
        mem_req_ready <= ({$random(seed)} % 3) != 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/cache_tb.sv
`default_nettype none

module cache_tb
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;
  localparam int MEM_NO  = 0;
  localparam int MEM_YES = 1;
  localparam int MEM_ANY = 2;

  logic  clk;
  logic  rest;
  logic  req_valid;
  logic  req_ready;
  logic  req_write;
  addr_t req_addr;
  be_t   req_be;
  word_t req_wdata;
  logic  rsp_valid;
  logic  rsp_ready;
  word_t rsp_data;
  logic  mem_req_valid;
  logic  mem_req_ready;
  logic  mem_req_write;
  addr_t mem_req_addr;
  be_t   mem_req_be;
  word_t mem_req_wdata;
  logic  mem_rsp_valid;
  word_t mem_rsp_data;

  integer seed = 32'he407_6fc9;
  logic   stall_rsp = 1'b0;
  int     mem_reads = 0;
  int     rsp_count = 0;
  int     read_count = 0;

  // Stimulus table, one entry per row in each queue.
  logic  row_write [$];
  addr_t row_addr  [$];
  be_t   row_be    [$];
  word_t row_wdata [$];
  int    row_mem   [$];
  logic  row_stall [$];

  // Expected memory contents.
  word_t ref_mem [addr_t];

  cache_top #(
    .SET_BITS (4)
  ) uut (
    .clk           (clk),
    .rest          (rest),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_be        (req_be),
    .req_wdata     (req_wdata),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_data      (rsp_data),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_be    (mem_req_be),
    .mem_req_wdata (mem_req_wdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  cache_mem_model u_mem (
    .clk           (clk),
    .rest          (rest),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_be    (mem_req_be),
    .mem_req_wdata (mem_req_wdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Client back-pressure, random stretches of low ready.
  always @(posedge clk) begin
    if (stall_rsp) begin
      rsp_ready <= ({$random(seed)} % 4) == 0;
    end else begin
      rsp_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (mem_req_valid && mem_req_ready && !mem_req_write) begin
      mem_reads <= mem_reads + 1;
    end
    if (rsp_valid && rsp_ready) begin
      rsp_count <= rsp_count + 1;
    end
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[ERROR] %0t: %s mismatch, got %h, expected %h",
                                  $time, what, actual, expected));
    end
  endtask

  task automatic add_row(input logic write, input addr_t addr, input be_t be,
                         input word_t wdata, input int mem, input logic stall);
    row_write.push_back(write);
    row_addr.push_back(addr);
    row_be.push_back(be);
    row_wdata.push_back(wdata);
    row_mem.push_back(mem);
    row_stall.push_back(stall);
  endtask

  function automatic word_t byte_mask(be_t be);
    word_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

  // Memory starts as the inverted address.
  function automatic word_t ref_read(addr_t addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return ~addr;
  endfunction

  task automatic hold_until_accepted();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_with_failure("Timeout: the cache never accepted the request.");
      end
    end while (!req_ready);
    req_valid <= 1'b0;
  endtask

  task automatic expect_mem_write(input addr_t addr, input be_t be, input word_t wdata);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_with_failure("Timeout: the write never reached memory.");
      end
    end while (!(mem_req_valid && mem_req_ready && mem_req_write));
    check_value("write address", mem_req_addr, {addr[31:2], 2'b00});
    check_value("write byte enable", word_t'(mem_req_be), word_t'(be));
    check_value("write data", mem_req_wdata & byte_mask(be), wdata & byte_mask(be));
  endtask

  task automatic collect_response(output word_t data);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_with_failure("Timeout: no read response arrived.");
      end
    end while (!(rsp_valid && rsp_ready));
    data = rsp_data;
  endtask

  task automatic run_row(input int i);
    int    reads_before;
    addr_t word_addr;
    word_t got;
    word_t merged;
    reads_before = mem_reads;
    word_addr    = {row_addr[i][31:2], 2'b00};
    stall_rsp <= row_stall[i];
    req_valid <= 1'b1;
    req_write <= row_write[i];
    req_addr  <= row_addr[i];
    req_be    <= row_be[i];
    req_wdata <= row_wdata[i];
    hold_until_accepted();
    if (row_write[i]) begin
      expect_mem_write(row_addr[i], row_be[i], row_wdata[i]);
      merged = ref_read(word_addr);
      merged = (merged & ~byte_mask(row_be[i])) | (row_wdata[i] & byte_mask(row_be[i]));
      ref_mem[word_addr] = merged;
    end else begin
      read_count++;
      collect_response(got);
      // Only the requested bytes are defined on a partial read.
      check_value($sformatf("row %0d read data", i), got & byte_mask(row_be[i]),
                  ref_read(word_addr) & byte_mask(row_be[i]));
    end
    if (row_mem[i] != MEM_ANY) begin
      check_value($sformatf("row %0d memory read count", i), mem_reads - reads_before,
                  (row_mem[i] == MEM_YES) ? 1 : 0);
    end
  endtask

  initial begin
    rest      = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_be    = '0;
    req_wdata = '0;
    rsp_ready = 1'b0;

    // Cold read, then a hit on the same word.
    add_row(1'b0, 32'h0000_0040, 4'hF, '0, MEM_YES, 1'b0);
    add_row(1'b0, 32'h0000_0040, 4'hF, '0, MEM_NO, 1'b0);
    // Partial write to a cached word, then the merged read.
    add_row(1'b1, 32'h0000_0040, 4'h3, 32'hA5A5_1234, MEM_NO, 1'b0);
    add_row(1'b0, 32'h0000_0040, 4'hF, '0, MEM_NO, 1'b0);
    // Write miss, read of the written bytes, then a full read.
    add_row(1'b1, 32'h0000_0080, 4'hC, 32'hBEEF_0000, MEM_NO, 1'b0);
    add_row(1'b0, 32'h0000_0080, 4'hC, '0, MEM_NO, 1'b0);
    add_row(1'b0, 32'h0000_0080, 4'hF, '0, MEM_YES, 1'b0);
    add_row(1'b0, 32'h0000_0080, 4'hF, '0, MEM_NO, 1'b0);
    // Client back-pressure.
    add_row(1'b0, 32'h0000_0040, 4'hF, '0, MEM_NO, 1'b1);
    add_row(1'b0, 32'h0000_0104, 4'hF, '0, MEM_YES, 1'b1);
    add_row(1'b0, 32'h0000_0104, 4'hF, '0, MEM_NO, 1'b1);
    add_row(1'b1, 32'h0000_0104, 4'h1, 32'h0000_005A, MEM_NO, 1'b1);
    add_row(1'b0, 32'h0000_0104, 4'hF, '0, MEM_NO, 1'b1);
    add_row(1'b0, 32'h0000_0208, 4'hF, '0, MEM_YES, 1'b1);
    add_row(1'b0, 32'h0000_0040, 4'hF, '0, MEM_NO, 1'b1);
    // Five tags in set 3 force an eviction.
    for (int pass = 0; pass < 2; pass++) begin
      for (int t = 1; t <= 5; t++) begin
        add_row(1'b0, (addr_t'(t) << 12) | 32'h0000_000C, 4'hF, '0, MEM_ANY, 1'b0);
      end
    end

    repeat (5) @(posedge clk);
    rest <= 1'b1;
    @(posedge clk);

    for (int i = 0; i < row_write.size(); i++) begin
      run_row(i);
    end

    // Let any stray response show up.
    stall_rsp <= 1'b0;
    repeat (10) @(posedge clk);
    if (rsp_count == read_count && !rsp_valid) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_with_failure($sformatf("Saw %0d read responses for %0d reads.",
                                  rsp_count, read_count));
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
common/cache_pkg.sv
design/cache_req_in.sv
cache_core/cache_tag_store.sv
cache_core/cache_data_store.sv
cache_core/cache_ctrl.sv
design/cache_rsp_out.sv
design/cache_top.sv
tests/cache_mem_model.sv
tests/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - common/cache_pkg.sv
  - design/cache_req_in.sv
  - cache_core/cache_tag_store.sv
  - cache_core/cache_data_store.sv
  - cache_core/cache_ctrl.sv
  - design/cache_rsp_out.sv
  - design/cache_top.sv
  - target: test
    files:
      - tests/cache_mem_model.sv
      - tests/cache_tb.sv
